/* hw/sel_axil_slave.sv */
// AXI4-Lite slave: write and read channel FSMs issuing single-cycle register-bank requests
`timescale 1ns/10ps
`default_nettype none

`include "sel_defines.svh"

module sel_axil_slave (
    input  logic                 s_axi_aclk,
    input  logic                 s_axi_aresetn,
    input  logic [31:0]          s_axi_awaddr,
    input  logic                 s_axi_awvalid,
    output logic                 s_axi_awready,
    input  logic [31:0]          s_axi_wdata,
    input  logic [3:0]           s_axi_wstrb,
    input  logic                 s_axi_wvalid,
    output logic                 s_axi_wready,
    output logic [1:0]           s_axi_bresp,
    output logic                 s_axi_bvalid,
    input  logic                 s_axi_bready,
    input  logic [31:0]          s_axi_araddr,
    input  logic                 s_axi_arvalid,
    output logic                 s_axi_arready,
    output logic [31:0]          s_axi_rdata,
    output logic [1:0]           s_axi_rresp,
    output logic                 s_axi_rvalid,
    input  logic                 s_axi_rready,
    input  sel_pkg::reg_rsp_t    wr_rsp,
    input  sel_pkg::reg_rsp_t    rd_rsp,
    output sel_pkg::reg_wr_req_t wr_req,
    output sel_pkg::reg_rd_req_t rd_req
);

    import sel_pkg::*;

    wr_state_e wr_state;
    rd_state_e rd_state;

    // address and data of a write are taken in either order
    logic aw_held;
    logic w_held;

    logic aw_fire;
    logic w_fire;
    logic ar_fire;

    logic [`SEL_OFFSET_W-1:0] wr_offset;
    logic [31:0]              wr_data;
    logic [3:0]               wr_strb;
    logic [`SEL_OFFSET_W-1:0] rd_offset;

    assign aw_fire = s_axi_awready && s_axi_awvalid;
    assign w_fire  = s_axi_wready && s_axi_wvalid;
    assign ar_fire = s_axi_arready && s_axi_arvalid;

    // write FSM
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            wr_state      <= WR_IDLE;
            aw_held       <= 1'b0;
            w_held        <= 1'b0;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        aw_held <= 1'b1;
                    end
                    if (w_fire) begin
                        w_held <= 1'b1;
                    end
                    // ready drops once the beat is held
                    s_axi_awready <= !aw_held && !aw_fire;
                    s_axi_wready  <= !w_held && !w_fire;
                    if (aw_held && w_held) begin
                        wr_state <= WR_EXEC;
                    end
                end
                WR_EXEC: begin
                    s_axi_bvalid <= 1'b1;
                    wr_state     <= WR_RESP;
                end
                WR_RESP: begin
                    if (s_axi_bready) begin
                        s_axi_bvalid <= 1'b0;
                        aw_held      <= 1'b0;
                        w_held       <= 1'b0;
                        wr_state     <= WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // write payload and response code
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            wr_offset <= s_axi_awaddr[`SEL_OFFSET_W-1:0];
        end
        if (w_fire) begin
            wr_data <= s_axi_wdata;
            wr_strb <= s_axi_wstrb;
        end
        if (wr_state == WR_EXEC) begin
            s_axi_bresp <= wr_rsp.err ? `SEL_RESP_SLVERR : `SEL_RESP_OKAY;
        end
    end

    always_comb begin
        wr_req.valid  = (wr_state == WR_EXEC);
        wr_req.kind   = REG_WRITE;
        wr_req.offset = wr_offset;
        wr_req.data   = wr_data;
        wr_req.strb   = wr_strb;
    end

    // read FSM, request cycle is RD_RESP before rvalid rises
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            rd_state      <= RD_IDLE;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    s_axi_arready <= !ar_fire;
                    if (ar_fire) begin
                        rd_state <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (!s_axi_rvalid) begin
                        s_axi_rvalid <= 1'b1;
                    end else if (s_axi_rready) begin
                        s_axi_rvalid <= 1'b0;
                        rd_state     <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // read payload
    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            rd_offset <= s_axi_araddr[`SEL_OFFSET_W-1:0];
        end
        if (rd_req.valid) begin
            s_axi_rdata <= rd_rsp.data;
            s_axi_rresp <= rd_rsp.err ? `SEL_RESP_SLVERR : `SEL_RESP_OKAY;
        end
    end

    always_comb begin
        rd_req.valid  = (rd_state == RD_RESP) && !s_axi_rvalid;
        rd_req.kind   = REG_READ;
        rd_req.offset = rd_offset;
    end

endmodule

`default_nettype wire

/* hw/sel_decoder_axil.sv */
// top level: AXI4-Lite slave front end joined to the select register bank
`timescale 1ns/10ps
`default_nettype none

`include "sel_defines.svh"

module sel_decoder_axil (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    input  logic [31:0]           s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    input  logic [31:0]           s_axi_wdata,
    input  logic [3:0]            s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    input  logic [31:0]           s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    output logic [31:0]           s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,
    output logic [`SEL_WIDTH-1:0] rd_sel,
    output logic [`SEL_WIDTH-1:0] wr_sel
);

    import sel_pkg::*;

    // separate write and read ports into the bank
    reg_wr_req_t wr_req;
    reg_rd_req_t rd_req;
    reg_rsp_t    wr_rsp;
    reg_rsp_t    rd_rsp;

    sel_axil_slave i_slave (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr_rsp        (wr_rsp),
        .rd_rsp        (rd_rsp),
        .wr_req        (wr_req),
        .rd_req        (rd_req)
    );

    sel_reg_bank i_regs (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wr_req        (wr_req),
        .rd_req        (rd_req),
        .wr_rsp        (wr_rsp),
        .rd_rsp        (rd_rsp),
        .rd_sel        (rd_sel),
        .wr_sel        (wr_sel)
    );

endmodule

`default_nettype wire

/* hw/sel_defines.svh */
// address map, field widths and response codes for the select decoder
`ifndef SEL_DEFINES_SVH
`define SEL_DEFINES_SVH

// decoded address bits, higher bits ignored
`define SEL_OFFSET_W 4

`define SEL_INDEX_W 4
`define SEL_WIDTH 16

// register offsets
`define SEL_OFF_RD_INDEX 4'h0
`define SEL_OFF_WR_INDEX 4'h4
`define SEL_OFF_RD_SEL 4'h8
`define SEL_OFF_WR_SEL 4'hC

// AXI response codes
`define SEL_RESP_OKAY 2'b00
`define SEL_RESP_SLVERR 2'b10

`endif

/* hw/sel_pkg.sv */
// types for the select decoder: channel FSM states, access kind, register request and response
`default_nettype none

`include "sel_defines.svh"

package sel_pkg;

    // write channel
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_EXEC = 2'd1,
        WR_RESP = 2'd2
    } wr_state_e;

    // read channel
    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_RESP = 1'b1
    } rd_state_e;

    typedef enum logic {
        REG_READ  = 1'b0,
        REG_WRITE = 1'b1
    } reg_kind_e;

    typedef struct packed {
        logic                     valid;
        reg_kind_e                kind;
        logic [`SEL_OFFSET_W-1:0] offset;
        logic [31:0]              data;
        logic [3:0]               strb;
    } reg_wr_req_t;

    typedef struct packed {
        logic                     valid;
        reg_kind_e                kind;
        logic [`SEL_OFFSET_W-1:0] offset;
    } reg_rd_req_t;

    // answered in the request cycle
    typedef struct packed {
        logic [31:0] data;
        logic        err;
    } reg_rsp_t;

endpackage

`default_nettype wire

/* hw/sel_reg_bank.sv */
// register bank: index registers, address decode with error response, one-hot select outputs
`timescale 1ns/10ps
`default_nettype none

`include "sel_defines.svh"

module sel_reg_bank (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    input  sel_pkg::reg_wr_req_t  wr_req,
    input  sel_pkg::reg_rd_req_t  rd_req,
    output sel_pkg::reg_rsp_t     wr_rsp,
    output sel_pkg::reg_rsp_t     rd_rsp,
    output logic [`SEL_WIDTH-1:0] rd_sel,
    output logic [`SEL_WIDTH-1:0] wr_sel
);

    import sel_pkg::*;

    logic [`SEL_INDEX_W-1:0] rd_index;
    logic [`SEL_INDEX_W-1:0] wr_index;

    // only the two index registers are writable
    logic wr_mapped;
    logic wr_commit;

    assign rd_sel = {{(`SEL_WIDTH-1){1'b0}}, 1'b1} << rd_index;
    assign wr_sel = {{(`SEL_WIDTH-1){1'b0}}, 1'b1} << wr_index;

    always_comb begin
        wr_mapped = (wr_req.kind == REG_WRITE) &&
                    ((wr_req.offset == `SEL_OFF_RD_INDEX) ||
                     (wr_req.offset == `SEL_OFF_WR_INDEX));
        wr_rsp.data = '0;
        wr_rsp.err  = wr_req.valid && !wr_mapped;
    end

    // index lives in byte 0, so strobe bit 0 qualifies the update
    assign wr_commit = wr_req.valid && wr_mapped && wr_req.strb[0];

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            rd_index <= '0;
            wr_index <= '0;
        end else if (wr_commit) begin
            if (wr_req.offset == `SEL_OFF_RD_INDEX) begin
                rd_index <= wr_req.data[`SEL_INDEX_W-1:0];
            end
            if (wr_req.offset == `SEL_OFF_WR_INDEX) begin
                wr_index <= wr_req.data[`SEL_INDEX_W-1:0];
            end
        end
    end

    // read mux, unmapped offsets give err with zero data
    always_comb begin
        rd_rsp.data = '0;
        rd_rsp.err  = 1'b0;
        if (rd_req.valid) begin
            if (rd_req.kind != REG_READ) begin
                rd_rsp.err = 1'b1;
            end else begin
                case (rd_req.offset)
                    `SEL_OFF_RD_INDEX: begin
                        rd_rsp.data = 32'(rd_index);
                    end
                    `SEL_OFF_WR_INDEX: begin
                        rd_rsp.data = 32'(wr_index);
                    end
                    `SEL_OFF_RD_SEL: begin
                        rd_rsp.data = 32'(rd_sel);
                    end
                    `SEL_OFF_WR_SEL: begin
                        rd_rsp.data = 32'(wr_sel);
                    end
                    default: begin
                        rd_rsp.err = 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the select decoder testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_sel_decoder_axil -f sel_decoder_axil.f > build.log 2>&1 \
    && ./obj_dir/Vtb_sel_decoder_axil > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

/* sel_decoder_axil.f */
+incdir+hw
hw/sel_pkg.sv
hw/sel_axil_slave.sv
hw/sel_reg_bank.sv
hw/sel_decoder_axil.sv
verification/sel_axil_assertions.sv
verification/tb_sel_decoder_axil.sv

/* verification/sel_axil_assertions.sv */
// concurrent assertions on the AXI4-Lite handshake rules, bound to the decoder top level
`timescale 1ns/10ps
`default_nettype none

module sel_axil_assertions (
    input wire        s_axi_aclk,
    input wire        s_axi_aresetn,
    input wire        s_axi_awready,
    input wire        s_axi_wready,
    input wire        s_axi_arready,
    input wire        s_axi_bvalid,
    input wire        s_axi_bready,
    input wire [1:0]  s_axi_bresp,
    input wire        s_axi_rvalid,
    input wire        s_axi_rready,
    input wire [31:0] s_axi_rdata,
    input wire [1:0]  s_axi_rresp
);

    // responses wait for the master
    a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
        else $error("rvalid dropped before rready");

    a_bresp_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> $stable(s_axi_bresp))
        else $error("bresp changed while bvalid waited");

    a_rdata_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> $stable(s_axi_rdata) && $stable(s_axi_rresp))
        else $error("rdata or rresp changed while rvalid waited");

    // all handshake outputs quiet in reset
    a_reset_quiet: assert property (@(posedge s_axi_aclk)
        !s_axi_aresetn |-> !(s_axi_awready || s_axi_wready || s_axi_arready ||
                             s_axi_bvalid || s_axi_rvalid))
        else $error("ready or valid high during reset");

endmodule

bind sel_decoder_axil sel_axil_assertions i_assert (.*);

`default_nettype wire

/* verification/tb_sel_decoder_axil.sv */
// testbench: clock, reset, random AXI4-Lite master, register model and checks
`timescale 1ns/10ps
`default_nettype none

`include "sel_defines.svh"

module tb_sel_decoder_axil;

    localparam int LIMIT   = 50;
    localparam int NUM_TXN = 400;

    logic        s_axi_aclk;
    logic        s_axi_aresetn;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic [15:0] rd_sel;
    logic [15:0] wr_sel;

    int unsigned cyc = 0;
    int unsigned err_count = 0;
    int unsigned timeout_count = 0;

    // register model
    logic [3:0] m_rd_index;
    logic [3:0] m_wr_index;

    sel_decoder_axil i_dut (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #5 s_axi_aclk = ~s_axi_aclk;
    end

    always @(posedge s_axi_aclk) begin
        cyc <= cyc + 1;
    end

    // bit i set exactly when i equals the index
    function automatic logic [15:0] one_hot(input logic [3:0] idx);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < 16; i++) begin
            v[i] = (i == idx);
        end
        return v;
    endfunction

    task automatic step_cycle();
        @(posedge s_axi_aclk);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h at cycle %0d",
                     name, exp, act, cyc);
            err_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at cycle %0d", what, cyc);
        timeout_count++;
    endtask

    // order 0 is AW first, 1 is W first, 2 is both together
    task automatic drive_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input int order, input int stall);
        int          t;
        int unsigned last_edge;
        logic        aw_go;
        logic        w_go;
        logic        aw_pend;
        logic        w_pend;
        logic [1:0]  exp_resp;
        logic [1:0]  held_resp;
        logic [3:0]  off;
        off = addr[3:0];
        exp_resp = `SEL_RESP_SLVERR;
        if (off == `SEL_OFF_RD_INDEX || off == `SEL_OFF_WR_INDEX) begin
            exp_resp = `SEL_RESP_OKAY;
            if (strb[0] && off == `SEL_OFF_RD_INDEX) begin
                m_rd_index = data[3:0];
            end
            if (strb[0] && off == `SEL_OFF_WR_INDEX) begin
                m_wr_index = data[3:0];
            end
        end
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = (order != 1);
        s_axi_wvalid  = (order != 0);
        aw_pend = 1'b1;
        w_pend = 1'b1;
        last_edge = 0;
        t = 0;
        while ((aw_pend || w_pend) && t < LIMIT) begin
            aw_go = s_axi_awvalid && s_axi_awready;
            w_go = s_axi_wvalid && s_axi_wready;
            step_cycle();
            t++;
            if (aw_go) begin
                aw_pend = 1'b0;
                s_axi_awvalid = 1'b0;
                last_edge = cyc;
            end
            if (w_go) begin
                w_pend = 1'b0;
                s_axi_wvalid = 1'b0;
                last_edge = cyc;
            end
            if (!aw_pend) begin
                s_axi_wvalid = w_pend;
            end
            if (!w_pend) begin
                s_axi_awvalid = aw_pend;
            end
        end
        if (aw_pend || w_pend) begin
            s_axi_awvalid = 1'b0;
            s_axi_wvalid = 1'b0;
            report_timeout("awready or wready");
            return;
        end
        t = 0;
        while (!s_axi_bvalid && t < LIMIT) begin
            step_cycle();
            t++;
        end
        if (!s_axi_bvalid) begin
            report_timeout("bvalid");
            return;
        end
        compare_value("bvalid latency", 32'd2, cyc - last_edge);
        compare_value("s_axi_bresp", {30'h0, exp_resp}, {30'h0, s_axi_bresp});
        compare_value("rd_sel", {16'h0, one_hot(m_rd_index)}, {16'h0, rd_sel});
        compare_value("wr_sel", {16'h0, one_hot(m_wr_index)}, {16'h0, wr_sel});
        held_resp = s_axi_bresp;
        repeat (stall) begin
            step_cycle();
            compare_value("s_axi_bvalid", 32'h1, {31'h0, s_axi_bvalid});
            compare_value("s_axi_bresp", {30'h0, held_resp}, {30'h0, s_axi_bresp});
        end
        s_axi_bready = 1'b1;
        step_cycle();
        s_axi_bready = 1'b0;
    endtask

    task automatic drive_read(input logic [31:0] addr, input int stall);
        int          t;
        int unsigned ar_edge;
        logic        go;
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        logic [31:0] held_data;
        exp_data = 32'h0;
        exp_resp = `SEL_RESP_OKAY;
        case (addr[3:0])
            `SEL_OFF_RD_INDEX: exp_data = {28'h0, m_rd_index};
            `SEL_OFF_WR_INDEX: exp_data = {28'h0, m_wr_index};
            `SEL_OFF_RD_SEL: exp_data = {16'h0, one_hot(m_rd_index)};
            `SEL_OFF_WR_SEL: exp_data = {16'h0, one_hot(m_wr_index)};
            default: exp_resp = `SEL_RESP_SLVERR;
        endcase
        s_axi_araddr = addr;
        s_axi_arvalid = 1'b1;
        go = 1'b0;
        t = 0;
        while (!go && t < LIMIT) begin
            go = s_axi_arvalid && s_axi_arready;
            step_cycle();
            t++;
        end
        s_axi_arvalid = 1'b0;
        if (!go) begin
            report_timeout("arready");
            return;
        end
        ar_edge = cyc;
        t = 0;
        while (!s_axi_rvalid && t < LIMIT) begin
            step_cycle();
            t++;
        end
        if (!s_axi_rvalid) begin
            report_timeout("rvalid");
            return;
        end
        compare_value("rvalid latency", 32'd1, cyc - ar_edge);
        compare_value("s_axi_rdata", exp_data, s_axi_rdata);
        compare_value("s_axi_rresp", {30'h0, exp_resp}, {30'h0, s_axi_rresp});
        held_data = s_axi_rdata;
        repeat (stall) begin
            step_cycle();
            compare_value("s_axi_rvalid", 32'h1, {31'h0, s_axi_rvalid});
            compare_value("s_axi_rdata", held_data, s_axi_rdata);
        end
        s_axi_rready = 1'b1;
        step_cycle();
        s_axi_rready = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] upper;
        logic [3:0]  off;
        logic [31:0] addr;
        void'($urandom(32'hb1da));
        s_axi_aresetn = 1'b1;
        s_axi_awaddr = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        m_rd_index = '0;
        m_wr_index = '0;
        #1 s_axi_aresetn = 1'b0;
        repeat (8) @(posedge s_axi_aclk);
        #1 s_axi_aresetn = 1'b1;
        step_cycle();
        for (int i = 0; i < NUM_TXN; i++) begin
            r = $urandom;
            upper = $urandom;
            // mostly mapped offsets, some unaligned
            if (r[2:0] < 3'd6) begin
                off = {r[4:3], 2'b00};
            end else begin
                off = {r[6:5], (r[8:7] == 2'b00) ? 2'b01 : r[8:7]};
            end
            addr = r[9] ? {upper[31:4], off} : {28'h0, off};
            if (r[10]) begin
                drive_write(addr, $urandom, r[14:11], int'(r[16:15]) % 3, int'(r[18:17]));
                if (off == `SEL_OFF_RD_INDEX || off == `SEL_OFF_WR_INDEX) begin
                    drive_read({28'h0, off}, 0);
                end
            end else begin
                drive_read(addr, int'(r[18:17]));
            end
        end
        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
